/* vlog.f */
+incdir+hdl
hdl/md4_pkg.sv
hdl/md4_state_if.sv
hdl/md4_block_load.sv
hdl/md4_step.sv
hdl/md4_round.sv
hdl/md4_digest_out.sv
hdl/md4_core.sv
tests/tb_clock.sv
tests/md4_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the md4 pipeline testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module md4_core_tb -o md4_core_sim
if [ $? -ne 0 ]; then echo "verilator build failed"; exit 1; fi
out=$(./obj_dir/md4_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then echo "simulation exited with status $status"; exit 1; fi
if echo "$out" | grep -q "^PASS: all tests$"; then exit 0; fi
echo "pass message not found in simulation output"
exit 1

/* tests/md4_golden.txt */
// each line: 4 message bytes in hex, first byte on the left, then the 128-bit md4 digest
// a zero digest is predicted by the testbench model, a nonzero one is a standard md4 value
61626364_00000000000000000000000000000000
74657374_db346d691d7acc4dc2625db19f9e3f52
31323334_00000000000000000000000000000000
7778797a_00000000000000000000000000000000
41424344_00000000000000000000000000000000
30303030_00000000000000000000000000000000
7a7a7a7a_00000000000000000000000000000000
68617368_00000000000000000000000000000000
6d643421_00000000000000000000000000000000
70697065_00000000000000000000000000000000
636f7265_00000000000000000000000000000000
64617461_00000000000000000000000000000000
20202020_00000000000000000000000000000000
61316232_00000000000000000000000000000000
00000000_00000000000000000000000000000000
ffffffff_00000000000000000000000000000000
deadbeef_00000000000000000000000000000000
80000001_00000000000000000000000000000000
6b657931_00000000000000000000000000000000
446f6e65_00000000000000000000000000000000

/* tests/md4_core_tb.sv */
`timescale 1ns/10ps

module md4_core_tb;
    localparam int LATENCY = 50;
    localparam int N_GOLD  = 20;
    localparam int N_RAND  = 200;
    localparam int SEED    = 32'h7863ff63;
    localparam int TEST_CYCLES = 9 + N_GOLD * (LATENCY + 1) + 3 * N_GOLD + N_RAND + 3 * LATENCY;
    localparam int SHIFTS [12] = '{3, 7, 11, 19, 3, 5, 9, 13, 3, 9, 11, 15};
    localparam int ORDER [48] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15,
                                  0, 4, 8, 12, 1, 5, 9, 13, 2, 6, 10, 14, 3, 7, 11, 15,
                                  0, 8, 4, 12, 2, 10, 6, 14, 1, 9, 5, 13, 3, 11, 7, 15};

    logic         clk;
    logic         rst_n;
    logic [31:0]  msg;
    logic [127:0] digest;
    logic [159:0] gold [N_GOLD];       // message then digest
    logic [127:0] expected [N_GOLD];
    int           cycle = 0;           // rising edges so far
    int           due_q [$];
    int           idx_q [$];
    logic [127:0] dig_q [$];

    tb_clock u_clock (.clk (clk));

    md4_core DUT (.clk (clk), .rst_n (rst_n), .msg (msg), .digest (digest));

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // standard md4 of a single padded block holding four bytes
    function automatic logic [127:0] md4_model(input logic [31:0] m);
        logic [31:0] x [16];
        logic [31:0] a, b, c, d, f, k, t;
        int          sh;
        for (int i = 0; i < 16; i++) x[i] = '0;
        x[0]  = swap_bytes(m);
        x[1]  = 32'h00000080;
        x[14] = 32'd32;            // bit count
        a = 32'h67452301;
        b = 32'hefcdab89;
        c = 32'h98badcfe;
        d = 32'h10325476;
        for (int i = 0; i < 48; i++)
        begin
            case (i / 16)
                0:       f = (b & c) | (~b & d);
                1:       f = (b & c) | (b & d) | (c & d);
                default: f = b ^ c ^ d;
            endcase
            k  = (i < 16) ? 32'h0 : (i < 32) ? 32'h5a827999 : 32'h6ed9eba1;
            sh = SHIFTS[(i / 16) * 4 + i % 4];
            t  = a + f + x[ORDER[i]] + k;
            t  = (t << sh) | (t >> (32 - sh));
            a  = d;
            d  = c;
            c  = b;
            b  = t;
        end
        return {swap_bytes(a + 32'h67452301), swap_bytes(b + 32'hefcdab89),
                swap_bytes(c + 32'h98badcfe), swap_bytes(d + 32'h10325476)};
    endfunction

    task automatic check_value(input logic [127:0] actual, input logic [127:0] want,
                               input int idx);
        if (actual !== want)
        begin
            $display("** Error at %0t: item %0d got %h, expected %h", $time, idx, actual, want);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_due();
        logic [127:0] want;
        int           idx;
        if (due_q.size() > 0 && due_q[0] == cycle)
        begin
            want = dig_q.pop_front();
            idx  = idx_q.pop_front();
            void'(due_q.pop_front());
            check_value(digest, want, idx);
        end
    endtask

    task automatic drive_item(input int idx);
        @(negedge clk);
        check_due();
        msg = gold[idx][159:128];
        due_q.push_back(cycle + LATENCY);   // sampled on the next edge
        dig_q.push_back(expected[idx]);
        idx_q.push_back(idx);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        check_due();
        msg = '0;
    endtask

    task automatic drain();
        while (due_q.size() > 0) drive_idle();
    endtask

    initial
    begin
        rst_n = 1'b0;
        msg   = '0;
        void'($urandom(SEED));
        $readmemh("tests/md4_golden.txt", gold);
        for (int i = 0; i < N_GOLD; i++)
        begin
            expected[i] = md4_model(gold[i][159:128]);
            if (gold[i][127:0] != '0) check_value(expected[i], gold[i][127:0], i);
        end
        repeat (5)
        begin
            @(negedge clk);
            check_value(digest, '0, -1);
        end
        rst_n = 1'b1;
        for (int i = 0; i < N_GOLD; i++)
        begin
            drive_item(i);
            repeat (LATENCY) drive_idle();
        end
        for (int i = 0; i < N_GOLD; i++) drive_item(i);
        drain();
        repeat (N_RAND) drive_item($urandom_range(N_GOLD - 1));
        drain();
        // reset in the middle of a stream
        for (int i = 0; i < N_GOLD; i++) drive_item(i);
        @(negedge clk);
        rst_n = 1'b0;
        msg   = '0;
        due_q.delete();
        dig_q.delete();
        idx_q.delete();
        repeat (3)
        begin
            @(negedge clk);
            check_value(digest, '0, -1);
        end
        rst_n = 1'b1;
        for (int i = N_GOLD - 1; i >= 0; i--) drive_item(i);
        drain();
        $display("PASS: all tests");
        $finish;
    end

    initial
    begin
        #((TEST_CYCLES + 200) * 100);
        $display("timeout: the digest checks did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end
endmodule : md4_core_tb

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock
#(
    parameter int PERIOD = 100
)
(
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end
endmodule : tb_clock

/* hdl/md4_core.sv */
`timescale 1ns/10ps

module md4_core
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  md4_pkg::md4_word_t   msg,
    output md4_pkg::md4_digest_t digest
);
    md4_state_if load_link ();
    md4_state_if r0_link ();
    md4_state_if r1_link ();
    md4_state_if r2_link ();

    md4_block_load u_load
    (
        .clk   (clk),
        .rst_n (rst_n),
        .msg   (msg),
        .out   (load_link)
    );

    // F round
    md4_round
    #(
        .ROUND (0)
    )
    u_round0
    (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (load_link),
        .out   (r0_link)
    );

    // G round
    md4_round
    #(
        .ROUND (1)
    )
    u_round1
    (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (r0_link),
        .out   (r1_link)
    );

    // H round
    md4_round
    #(
        .ROUND (2)
    )
    u_round2
    (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (r1_link),
        .out   (r2_link)
    );

    md4_digest_out u_out
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .in     (r2_link),
        .digest (digest)
    );

endmodule : md4_core

/* hdl/md4_digest_out.sv */
`timescale 1ns/10ps
`include "md4_defines.svh"

module md4_digest_out
(
    input  logic                 clk,
    input  logic                 rst_n,
    md4_state_if.dst             in,
    output md4_pkg::md4_digest_t digest
);
    import md4_pkg::*;

    md4_word_t sum_a;
    md4_word_t sum_b;
    md4_word_t sum_c;
    md4_word_t sum_d;

    function automatic md4_word_t bswap(input md4_word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // after 48 steps the lanes hold A, B, C, D again
    assign sum_a = in.a + `MD4_IV_A;
    assign sum_b = in.b + `MD4_IV_B;
    assign sum_c = in.c + `MD4_IV_C;
    assign sum_d = in.d + `MD4_IV_D;

    // low byte of A is the first digest byte
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            digest <= '0;
        end
        else
        begin
            digest <= {bswap(sum_a), bswap(sum_b), bswap(sum_c), bswap(sum_d)};
        end
    end

endmodule : md4_digest_out

/* hdl/md4_round.sv */
`timescale 1ns/10ps
`include "md4_defines.svh"

module md4_round
#(
    parameter int ROUND = 0
)
(
    input  logic     clk,
    input  logic     rst_n,
    md4_state_if.dst in,
    md4_state_if.src out
);
    localparam int N = `MD4_ROUND_STEPS;

    // links between neighbouring steps
    md4_state_if link [N-1] ();

    genvar i;
    generate
        for (i = 0; i < N; i++)
        begin : g_step
            if (i == 0)
            begin : g_first
                md4_step
                #(
                    .STEP (ROUND * N)
                )
                u_step
                (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .in    (in),
                    .out   (link[0])
                );
            end
            else if (i == N - 1)
            begin : g_last
                md4_step
                #(
                    .STEP (ROUND * N + i)
                )
                u_step
                (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .in    (link[i-1]),
                    .out   (out)
                );
            end
            else
            begin : g_mid
                md4_step
                #(
                    .STEP (ROUND * N + i)
                )
                u_step
                (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .in    (link[i-1]),
                    .out   (link[i])
                );
            end
        end
    endgenerate

endmodule : md4_round

/* hdl/md4_step.sv */
`timescale 1ns/10ps
`include "md4_defines.svh"

module md4_step
#(
    parameter int STEP = 0
)
(
    input  logic     clk,
    input  logic     rst_n,
    md4_state_if.dst in,
    md4_state_if.src out
);
    import md4_pkg::*;

    localparam int ROUND = STEP / `MD4_ROUND_STEPS;
    localparam int POS   = STEP % `MD4_ROUND_STEPS;

    // four shift amounts per round
    localparam int SHIFT_TBL [12] = '{3, 7, 11, 19, 3, 5, 9, 13, 3, 9, 11, 15};
    localparam int SHIFT = SHIFT_TBL[ROUND * 4 + POS % 4];

    // block word order of each round
    function automatic int word_idx(input int rnd, input int pos);
        int idx;
        case (rnd)
            0:       idx = pos;
            1:       idx = (pos % 4) * 4 + pos / 4;
            default: idx = {28'd0, pos[0], pos[1], pos[2], pos[3]};   // bit reversed
        endcase
        return idx;
    endfunction

    localparam int X_IDX = word_idx(ROUND, POS);

    localparam md4_word_t K_ADD = (ROUND == 0) ? '0 :
                                  (ROUND == 1) ? `MD4_K1 : `MD4_K2;

    md4_word_t f_val;
    md4_word_t x_val;
    md4_word_t sum;
    md4_word_t rot;

    always_comb
    begin
        case (ROUND)
            0:       f_val = in.d ^ (in.b & (in.c ^ in.d));          // F selects c or d
            1:       f_val = (in.b & (in.c | in.d)) | (in.c & in.d); // G majority vote
            default: f_val = in.b ^ in.c ^ in.d;                     // H parity
        endcase
    end

    // only words 0, 1 and 14 are nonzero for a four byte message
    always_comb
    begin
        case (X_IDX)
            0:       x_val = in.msg;
            1:       x_val = `MD4_PAD_WORD1;
            14:      x_val = `MD4_LEN_WORD14;
            default: x_val = '0;
        endcase
    end

    assign sum = in.a + f_val + x_val + K_ADD;
    assign rot = (sum << SHIFT) | (sum >> (`MD4_WORD_W - SHIFT));

    // lanes turn by one so the next step sees its target in a
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out.a   <= '0;
            out.b   <= '0;
            out.c   <= '0;
            out.d   <= '0;
            out.msg <= '0;
        end
        else
        begin
            out.a   <= in.d;
            out.b   <= rot;
            out.c   <= in.b;
            out.d   <= in.c;
            out.msg <= in.msg;   // item keeps its own message
        end
    end

endmodule : md4_step

/* hdl/md4_block_load.sv */
`timescale 1ns/10ps
`include "md4_defines.svh"

module md4_block_load
(
    input  logic               clk,
    input  logic               rst_n,
    input  md4_pkg::md4_word_t msg,
    md4_state_if.src           out
);
    import md4_pkg::*;

    md4_word_t msg_le;

    // MD4 wants port byte 0 in the low byte
    assign msg_le = {msg[7:0], msg[15:8], msg[23:16], msg[31:24]};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out.a   <= '0;
            out.b   <= '0;
            out.c   <= '0;
            out.d   <= '0;
            out.msg <= '0;
        end
        else
        begin
            out.a   <= `MD4_IV_A;
            out.b   <= `MD4_IV_B;
            out.c   <= `MD4_IV_C;
            out.d   <= `MD4_IV_D;
            out.msg <= msg_le;
        end
    end

endmodule : md4_block_load

/* hdl/md4_state_if.sv */
`timescale 1ns/10ps

// chaining state of one item plus its message word
interface md4_state_if;
    import md4_pkg::*;

    md4_word_t a;
    md4_word_t b;
    md4_word_t c;
    md4_word_t d;
    md4_word_t msg;   // block word 0 in little endian order

    modport src
    (
        output a,
        output b,
        output c,
        output d,
        output msg
    );

    modport dst
    (
        input a,
        input b,
        input c,
        input d,
        input msg
    );

endinterface : md4_state_if

/* hdl/md4_pkg.sv */
`include "md4_defines.svh"

package md4_pkg;

    // one MD4 word
    typedef logic [`MD4_WORD_W-1:0]   md4_word_t;

    // final hash with the first byte in the top bits
    typedef logic [`MD4_DIGEST_W-1:0] md4_digest_t;

endpackage : md4_pkg

/* hdl/md4_defines.svh */
`ifndef MD4_DEFINES_SVH
`define MD4_DEFINES_SVH

// widths
`define MD4_WORD_W      32
`define MD4_DIGEST_W    128

// pipeline shape
`define MD4_ROUND_STEPS 16
`define MD4_ROUNDS      3

// initial chaining value
`define MD4_IV_A        32'h67452301
`define MD4_IV_B        32'hefcdab89
`define MD4_IV_C        32'h98badcfe
`define MD4_IV_D        32'h10325476

// constants of rounds 2 and 3
`define MD4_K1          32'h5a827999
`define MD4_K2          32'h6ed9eba1

// fixed block words for a four byte message
`define MD4_PAD_WORD1   32'h00000080
`define MD4_LEN_WORD14  32'd32

`endif
